// ==== include/dac_params.svh ====
// dac transport-layer test source, shared parameters
// fifo depth, register port width and register map
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// **************************************************
// sample fifo
// **************************************************

// entries between generator and formatter
`define DAC_FIFO_DEPTH 8

// **************************************************
// register port
// **************************************************

// word address width of the write port
`define DAC_ADDR_W 4

// register addresses
`define DAC_REG_CTRL  0
`define DAC_REG_INIT  1
`define DAC_REG_INCR  2
`define DAC_REG_PAT0  3
`define DAC_REG_PAT1  4
`define DAC_REG_SCALE 5

// ctrl register fields
`define DAC_CTRL_ENABLE_BIT 0
// 1 selects offset binary output
`define DAC_CTRL_FORMAT_BIT 1
`define DAC_CTRL_SRC_LSB    2

`endif

// ==== source/dac_reg_pkg.sv ====
// dac register-side types
// address and data words, source select and the decoded configuration
`default_nettype none

`include "dac_params.svh"

package dac_reg_pkg;

  // **************************************************
  // register port words
  // **************************************************

  typedef logic [`DAC_ADDR_W-1:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // sample source, ctrl bits 3:2
  typedef enum logic [1:0] {
    SRC_RAMP    = 2'd0,
    SRC_PATTERN = 2'd1,
    SRC_ZERO    = 2'd2
  } dac_src_e;

  // **************************************************
  // decoded configuration
  // **************************************************

  typedef struct packed {
    // generator runs while set
    logic      enable;
    // invert msb at the output
    logic      offset_bin;
    dac_src_e  src;
    // ramp start value and step
    reg_data_t init;
    reg_data_t incr;
    // alternating pattern words, pat0 first
    reg_data_t pat0;
    reg_data_t pat1;
    // q2.14 gain, 0x4000 is unity
    reg_data_t scale;
  } dac_cfg_t;

endpackage

`default_nettype wire

// ==== source/dac_stream_pkg.sv ====
// dac sample-side types
// sample and gain words, the stream beat and the generator states
`default_nettype none

package dac_stream_pkg;

  // two's complement converter sample
  typedef logic signed [15:0] sample_t;

  // q2.14, 0x4000 is unity
  typedef logic signed [15:0] gain_t;

  // one beat on the internal streams
  typedef struct packed {
    sample_t data;
    // last sample before enable dropped
    logic    last_of_run;
  } sample_beat_t;

  // tone generator fsm
  typedef enum logic {
    GEN_IDLE = 1'b0,
    GEN_RUN  = 1'b1
  } gen_state_e;

endpackage

`default_nettype wire

// ==== source/dac_regmap.sv ====
// dac register map
// one-cycle write port into the configuration struct, plus a start pulse
`default_nettype none

`include "dac_params.svh"

module dac_regmap
  import dac_reg_pkg::*;
(
  input  wire            spi_clk,
  input  wire            rst,
  input  wire            up_wreq,
  input  wire reg_addr_t up_waddr,
  input  wire reg_data_t up_wdata,
  output dac_cfg_t       cfg,
  output logic           start
);

  // ctrl write that also enables
  logic ctrl_go;

  assign ctrl_go = up_wreq && (up_waddr == reg_addr_t'(`DAC_REG_CTRL)) &&
                   up_wdata[`DAC_CTRL_ENABLE_BIT];

  // **************************************************
  // configuration registers
  // **************************************************

  always_ff @(posedge spi_clk) begin
    if (rst) begin
      // all zero, generator disabled and gain zero
      cfg <= '0;
    end else if (up_wreq) begin
      case (up_waddr)
        reg_addr_t'(`DAC_REG_CTRL): begin
          cfg.enable     <= up_wdata[`DAC_CTRL_ENABLE_BIT];
          cfg.offset_bin <= up_wdata[`DAC_CTRL_FORMAT_BIT];
          cfg.src        <= dac_src_e'(up_wdata[`DAC_CTRL_SRC_LSB +: 2]);
        end
        reg_addr_t'(`DAC_REG_INIT):  cfg.init  <= up_wdata;
        reg_addr_t'(`DAC_REG_INCR):  cfg.incr  <= up_wdata;
        reg_addr_t'(`DAC_REG_PAT0):  cfg.pat0  <= up_wdata;
        reg_addr_t'(`DAC_REG_PAT1):  cfg.pat1  <= up_wdata;
        reg_addr_t'(`DAC_REG_SCALE): cfg.scale <= up_wdata;
        // unknown addresses dropped
        default: ;
      endcase
    end
  end

  // **************************************************
  // start pulse
  // **************************************************

  // same edge as the ctrl update, one cycle wide
  always_ff @(posedge spi_clk) begin
    if (rst) begin
      start <= 1'b0;
    end else begin
      start <= ctrl_go;
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_tone_gen.sv ====
// dac tone generator
// ramp, two-word pattern or zero samples on a valid/ready stream
`default_nettype none

module dac_tone_gen
  import dac_reg_pkg::*;
  import dac_stream_pkg::*;
(
  input  wire           spi_clk,
  input  wire           rst,
  input  wire dac_cfg_t cfg,
  input  wire           start,
  output logic          gen_valid,
  input  wire           gen_ready,
  output sample_beat_t  gen_beat
);

  gen_state_e state;

  // ramp offset from init, n * incr mod 2^16
  reg_data_t  ramp_off;
  // low bit of the sample index, picks pat0 or pat1
  logic       odd_phase;
  logic       beat_acc;
  sample_t    ramp_val;

  assign gen_valid = (state == GEN_RUN);
  assign beat_acc  = gen_valid && gen_ready;

  // init read fresh each beat
  assign ramp_val = sample_t'(cfg.init + ramp_off);

  // **************************************************
  // sample select
  // **************************************************

  always_comb begin
    // disabled means this beat closes the run
    gen_beat.last_of_run = !cfg.enable;
    case (cfg.src)
      SRC_RAMP:    gen_beat.data = ramp_val;
      SRC_PATTERN: gen_beat.data = odd_phase ? sample_t'(cfg.pat1) : sample_t'(cfg.pat0);
      // zero, and the unused code 3
      default:     gen_beat.data = '0;
    endcase
  end

  // **************************************************
  // fsm and sequence counters
  // **************************************************

  always_ff @(posedge spi_clk) begin
    if (rst) begin
      state     <= GEN_IDLE;
      ramp_off  <= '0;
      odd_phase <= 1'b0;
    end else if (start) begin
      // new run from index 0, also while running
      state     <= GEN_RUN;
      ramp_off  <= '0;
      odd_phase <= 1'b0;
    end else if (beat_acc) begin
      // advance one sample per accepted beat
      ramp_off  <= ramp_off + cfg.incr;
      odd_phase <= !odd_phase;
      if (!cfg.enable) begin
        state <= GEN_IDLE;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_sample_fifo.sv ====
// dac sample fifo
// circular buffer of sample beats, read and write in the same cycle
`default_nettype none

`include "dac_params.svh"

module dac_sample_fifo
  import dac_stream_pkg::*;
(
  input  wire               spi_clk,
  input  wire               rst,
  input  wire               in_valid,
  output logic              in_ready,
  input  wire sample_beat_t in_beat,
  output logic              out_valid,
  input  wire               out_ready,
  output sample_beat_t      out_beat
);

  localparam int DEPTH = `DAC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  sample_beat_t     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // occupancy, 0 to DEPTH
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // full stalls the generator
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_beat  = mem[rd_ptr];

  assign wr_en = in_valid && in_ready;
  assign rd_en = out_valid && out_ready;

  // **************************************************
  // storage
  // **************************************************

  always_ff @(posedge spi_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_beat;
    end
  end

  // **************************************************
  // pointers and count
  // **************************************************

  always_ff @(posedge spi_clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        // explicit wrap, depth need not be a power of two
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // both at once leaves count alone
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_stream_formatter.sv ====
// dac stream formatter
// q2.14 gain and optional offset binary, one output register stage
`default_nettype none

module dac_stream_formatter
  import dac_reg_pkg::*;
  import dac_stream_pkg::*;
(
  input  wire               spi_clk,
  input  wire               rst,
  input  wire dac_cfg_t     cfg,
  input  wire               in_valid,
  output logic              in_ready,
  input  wire sample_beat_t in_beat,
  output logic              m_axis_dds_valid,
  input  wire               m_axis_dds_ready,
  output sample_t           m_axis_dds_data
);

  gain_t              gain;
  logic signed [31:0] product;
  sample_t            scaled;
  sample_t            fmt_data;

  // **************************************************
  // gain and format
  // **************************************************

  assign gain = gain_t'(cfg.scale);

  // signed 16x16, full 32-bit product
  assign product = in_beat.data * gain;

  // drop the 14 fraction bits, wraps on overflow
  assign scaled = sample_t'(product[29:14]);

  // offset binary is an msb flip
  assign fmt_data = {scaled[15] ^ cfg.offset_bin, scaled[14:0]};

  // **************************************************
  // output register
  // **************************************************

  // accept when empty or draining this cycle
  assign in_ready = !m_axis_dds_valid || m_axis_dds_ready;

  always_ff @(posedge spi_clk) begin
    if (rst) begin
      m_axis_dds_valid <= 1'b0;
    end else if (in_ready) begin
      m_axis_dds_valid <= in_valid;
    end
  end

  // data held while stalled
  always_ff @(posedge spi_clk) begin
    if (in_valid && in_ready) begin
      m_axis_dds_data <= fmt_data;
    end
  end

endmodule

`default_nettype wire

// ==== source/dac_tpl_top.sv ====
// dac transport-layer test source, top level
// register map, tone generator, sample fifo and output formatter
`default_nettype none

module dac_tpl_top
  import dac_reg_pkg::*;
  import dac_stream_pkg::*;
(
  input  wire            spi_clk,
  input  wire            rst,
  input  wire            up_wreq,
  input  wire reg_addr_t up_waddr,
  input  wire reg_data_t up_wdata,
  input  wire            m_axis_dds_ready,
  output logic           m_axis_dds_valid,
  output sample_t        m_axis_dds_data
);

  // configuration to all blocks
  dac_cfg_t     cfg;
  logic         start;

  // generator to fifo
  logic         gen_valid;
  logic         gen_ready;
  sample_beat_t gen_beat;

  // fifo to formatter
  logic         fifo_valid;
  logic         fifo_ready;
  sample_beat_t fifo_beat;

  // **************************************************
  // register map
  // **************************************************

  dac_regmap i_regmap (
    .spi_clk  (spi_clk),
    .rst      (rst),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .cfg      (cfg),
    .start    (start)
  );

  // **************************************************
  // datapath, producer to buffer to consumer
  // **************************************************

  dac_tone_gen i_tone_gen (
    .spi_clk   (spi_clk),
    .rst       (rst),
    .cfg       (cfg),
    .start     (start),
    .gen_valid (gen_valid),
    .gen_ready (gen_ready),
    .gen_beat  (gen_beat)
  );

  dac_sample_fifo i_fifo (
    .spi_clk   (spi_clk),
    .rst       (rst),
    .in_valid  (gen_valid),
    .in_ready  (gen_ready),
    .in_beat   (gen_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready),
    .out_beat  (fifo_beat)
  );

  dac_stream_formatter i_formatter (
    .spi_clk          (spi_clk),
    .rst              (rst),
    .cfg              (cfg),
    .in_valid         (fifo_valid),
    .in_ready         (fifo_ready),
    .in_beat          (fifo_beat),
    .m_axis_dds_valid (m_axis_dds_valid),
    .m_axis_dds_ready (m_axis_dds_ready),
    .m_axis_dds_data  (m_axis_dds_data)
  );

endmodule

`default_nettype wire

// ==== verification/dac_tpl_asserts.sv ====
// dac transport-layer test source, stream handshake assertions
// bound into the top level, counts its own failures
`default_nettype none

module dac_tpl_asserts
  import dac_stream_pkg::*;
(
  input wire               spi_clk,
  input wire               rst,
  input wire               gen_valid,
  input wire               gen_ready,
  input wire sample_beat_t gen_beat,
  input wire               fifo_valid,
  input wire               m_axis_dds_valid,
  input wire               m_axis_dds_ready,
  input wire sample_t      m_axis_dds_data
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // **************************************************
  // handshake hold rules
  // **************************************************

  // last_of_run may rise while stalled, so only data is held
  gen_hold: assert property (@(posedge spi_clk) disable iff (rst)
    gen_valid && !gen_ready |=> gen_valid && $stable(gen_beat.data))
    else begin
      fail_count++;
      $error("gen beat dropped or changed while stalled");
    end

  out_hold: assert property (@(posedge spi_clk) disable iff (rst)
    m_axis_dds_valid && !m_axis_dds_ready |=> m_axis_dds_valid && $stable(m_axis_dds_data))
    else begin
      fail_count++;
      $error("m_axis_dds beat dropped or changed while stalled");
    end

  // closing beat taken, no new beat follows
  run_end: assert property (@(posedge spi_clk) disable iff (rst)
    gen_valid && gen_ready && gen_beat.last_of_run |=> !gen_valid)
    else begin
      fail_count++;
      $error("generator kept running after the last beat of a run");
    end

  // first cycle out of reset, all streams idle
  reset_idle: assert property (@(posedge spi_clk)
    $fell(rst) |-> !gen_valid && !fifo_valid && !m_axis_dds_valid)
    else begin
      fail_count++;
      $error("valid high in the cycle after reset");
    end

endmodule

bind dac_tpl_top dac_tpl_asserts u_asserts (
  .spi_clk          (spi_clk),
  .rst              (rst),
  .gen_valid        (gen_valid),
  .gen_ready        (gen_ready),
  .gen_beat         (gen_beat),
  .fifo_valid       (fifo_valid),
  .m_axis_dds_valid (m_axis_dds_valid),
  .m_axis_dds_ready (m_axis_dds_ready),
  .m_axis_dds_data  (m_axis_dds_data)
);

`default_nettype wire

// ==== verification/dac_tpl_tb.sv ====
// dac transport-layer test source, testbench
// register writes, random output back-pressure and a reference model
`default_nettype none

`include "dac_params.svh"

module dac_tpl_tb
  import dac_reg_pkg::*;
  import dac_stream_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // sum of the per-run sample counts below
  localparam int TOTAL_SAMPLES = 270;

  logic      spi_clk = 1'b0;
  logic      rst;
  logic      up_wreq;
  reg_addr_t up_waddr;
  reg_data_t up_wdata;
  logic      m_axis_dds_ready;
  logic      m_axis_dds_valid;
  sample_t   m_axis_dds_data;

  // expected configuration, mirrors what was written
  dac_src_e    exp_src;
  logic        exp_fmt;
  logic [15:0] exp_init;
  logic [15:0] exp_incr;
  logic [15:0] exp_pat0;
  logic [15:0] exp_pat1;
  logic [15:0] exp_scale;

  int          errors = 0;
  int          assert_fails;
  int          rx_index = 0;
  logic        heavy_bp = 1'b0;
  logic [31:0] rnd = 32'd62;

  dac_tpl_top u_dut (
    .spi_clk          (spi_clk),
    .rst              (rst),
    .up_wreq          (up_wreq),
    .up_waddr         (up_waddr),
    .up_wdata         (up_wdata),
    .m_axis_dds_ready (m_axis_dds_ready),
    .m_axis_dds_valid (m_axis_dds_valid),
    .m_axis_dds_data  (m_axis_dds_data)
  );

  // 40 ns period
  always #20 spi_clk = ~spi_clk;

  // **************************************************
  // helpers
  // **************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // sample n of a run, then gain and format
  function automatic logic [15:0] expected_sample(input int n);
    logic [31:0]        ramp;
    logic [15:0]        raw;
    logic signed [31:0] prod;
    logic [15:0]        res;
    ramp = 32'(exp_init) + 32'(n) * 32'(exp_incr);
    case (exp_src)
      SRC_RAMP:    raw = ramp[15:0];
      SRC_PATTERN: raw = (n % 2 == 0) ? exp_pat0 : exp_pat1;
      default:     raw = 16'h0000;
    endcase
    prod = $signed(raw) * $signed(exp_scale);
    // q2.14 back to q1.15 range, wraps
    res = prod[29:14];
    if (exp_fmt) begin
      res[15] = ~res[15];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input int idx, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns %s[%0d]: got 0x%04h expected 0x%04h",
               $time, name, idx, actual, expected);
    end
  endtask

  task automatic write_reg(input int addr, input logic [15:0] data);
    @(posedge spi_clk);
    #2;
    up_wreq  = 1'b1;
    up_waddr = reg_addr_t'(addr);
    up_wdata = data;
    @(posedge spi_clk);
    #2;
    up_wreq  = 1'b0;
  endtask

  task automatic configure(input dac_src_e src, input logic fmt, input logic [15:0] init,
                           input logic [15:0] incr, input logic [15:0] pat0,
                           input logic [15:0] pat1, input logic [15:0] scale);
    exp_src   = src;
    exp_fmt   = fmt;
    exp_init  = init;
    exp_incr  = incr;
    exp_pat0  = pat0;
    exp_pat1  = pat1;
    exp_scale = scale;
    write_reg(`DAC_REG_INIT, init);
    write_reg(`DAC_REG_INCR, incr);
    write_reg(`DAC_REG_PAT0, pat0);
    write_reg(`DAC_REG_PAT1, pat1);
    write_reg(`DAC_REG_SCALE, scale);
  endtask

  // start, collect n samples, disable and wait for the pipe to drain
  task automatic run_samples(input int n, input logic heavy);
    int last;
    int quiet;
    heavy_bp = heavy;
    rx_index = 0;
    write_reg(`DAC_REG_CTRL, {12'h000, exp_src, exp_fmt, 1'b1});
    wait (rx_index >= n);
    heavy_bp = 1'b0;
    // keep src and format, drop enable only
    write_reg(`DAC_REG_CTRL, {12'h000, exp_src, exp_fmt, 1'b0});
    last  = rx_index;
    quiet = 0;
    while (quiet < 20) begin
      @(posedge spi_clk);
      if (rx_index == last) begin
        quiet++;
      end else begin
        quiet = 0;
        last  = rx_index;
      end
    end
  endtask

  // **************************************************
  // back-pressure and compare
  // **************************************************

  always @(posedge spi_clk) begin
    #2;
    rnd = xorshift32(rnd);
    // heavy is one cycle in four, normal three in four
    m_axis_dds_ready = heavy_bp ? (rnd[1:0] == 2'b00) : (rnd[1:0] != 2'b00);
  end

  // handshake taken on the next rising edge
  always @(negedge spi_clk) begin
    if (!rst && m_axis_dds_valid && m_axis_dds_ready) begin
      check_value("m_axis_dds_data", rx_index, m_axis_dds_data, expected_sample(rx_index));
      rx_index++;
    end
  end

  initial begin
    repeat (TOTAL_SAMPLES * 8 + 200) @(posedge spi_clk);
    $display("timeout: the output stream stopped before all runs finished");
    $display(">>> FAIL");
    $finish;
  end

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    rst              = 1'b1;
    up_wreq          = 1'b0;
    up_waddr         = '0;
    up_wdata         = '0;
    m_axis_dds_ready = 1'b0;
    repeat (2) @(posedge spi_clk);
    #2;
    rst = 1'b0;

    // ramp through the 16-bit wrap, unity gain
    configure(SRC_RAMP, 1'b0, 16'h7FF0, 16'h0003, 16'h0000, 16'h0000, 16'h4000);
    run_samples(40, 1'b0);
    // pattern under heavy back-pressure, fifo fills
    configure(SRC_PATTERN, 1'b0, 16'h0000, 16'h0000, 16'h1234, 16'hA5C3, 16'h4000);
    run_samples(60, 1'b1);
    // gain of one half, then 1.5
    configure(SRC_RAMP, 1'b0, 16'hC000, 16'h0123, 16'h0000, 16'h0000, 16'h2000);
    run_samples(30, 1'b0);
    configure(SRC_RAMP, 1'b0, 16'h1000, 16'h0321, 16'h0000, 16'h0000, 16'h6000);
    run_samples(30, 1'b0);
    // offset binary pattern
    configure(SRC_PATTERN, 1'b1, 16'h0000, 16'h0000, 16'h0100, 16'hFF00, 16'h4000);
    run_samples(30, 1'b0);
    // zero source, both formats
    configure(SRC_ZERO, 1'b0, 16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h7FFF);
    run_samples(20, 1'b0);
    configure(SRC_ZERO, 1'b1, 16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h7FFF);
    run_samples(20, 1'b0);
    // restart, second run must begin at index 0 again
    configure(SRC_RAMP, 1'b0, 16'h0100, 16'h0011, 16'h0000, 16'h0000, 16'h4000);
    run_samples(20, 1'b0);
    configure(SRC_RAMP, 1'b0, 16'h0200, 16'h0007, 16'h0000, 16'h0000, 16'h4000);
    run_samples(20, 1'b0);

    assert_fails = u_dut.u_asserts.fail_count;
    $display("result: %0d data errors, %0d assertion failures", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
source/dac_reg_pkg.sv
source/dac_stream_pkg.sv
source/dac_regmap.sv
source/dac_tone_gen.sv
source/dac_sample_fifo.sv
source/dac_stream_formatter.sv
source/dac_tpl_top.sv
verification/dac_tpl_asserts.sv
verification/dac_tpl_tb.sv
